// ==== design/ec_pkg.sv ====
/* Range coder package
   Request word layouts, controller states and the coder constants */
package ec_pkg;

  // Range and shift-count widths
  localparam int EC_RANGE_W = 16;
  localparam int EC_D_W = 5;

  // Probability floor per symbol
  localparam logic [EC_RANGE_W-1:0] EC_MIN_PROB = 16'd4;

  // Range right after init, 0.5 in Q16
  localparam logic [EC_RANGE_W-1:0] EC_RANGE_INIT = 16'd32768;

  // CDF request, bounds in inverse Q15 form
  typedef struct packed {
    logic [15:0] fl;
    logic [15:0] fh;
    logic [3:0]  sym;
    logic [3:0]  nsyms;
  } ec_cdf_req_t;

  // Equiprobable booleans, bit 0 coded first
  typedef struct packed {
    logic [34:0] reserved;
    logic [1:0]  count;
    logic [2:0]  bits;
  } ec_bool_req_t;

  // Same 40-bit request word, decoded per req_is_bool
  typedef union packed {
    ec_cdf_req_t  cdf;
    ec_bool_req_t boolean;
  } ec_req_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    INIT,
    ENCODE,
    DRAIN
  } ec_state_t;

endpackage

// ==== design/leading_zero.sv ====
/* Leading-zero counter
   Two-level priority tree over four nibbles of a 16-bit range */
`timescale 1ns/1ps

module leading_zero (
  input  logic [ec_pkg::EC_RANGE_W-1:0] in_range,
  output logic                          v,
  output logic [ec_pkg::EC_D_W-1:0]     lzc_out
);

  logic [3:0] nib_nz;
  logic [1:0] nib_cnt [4];

  // First level, zeros inside one nibble
  function automatic logic [1:0] nib_lzc(input logic [3:0] nib);
    if (nib[3]) begin
      return 2'd0;
    end else if (nib[2]) begin
      return 2'd1;
    end else if (nib[1]) begin
      return 2'd2;
    end
    return 2'd3;
  endfunction

  for (genvar i = 0; i < 4; i++) begin : g_nib
    assign nib_nz[i]  = |in_range[4*i +: 4];
    assign nib_cnt[i] = nib_lzc(in_range[4*i +: 4]);
  end

  // Low when no bit is set
  assign v = |nib_nz;

  // Second level, first nonzero nibble from the top
  always_comb begin
    if (nib_nz[3]) begin
      lzc_out = {3'd0, nib_cnt[3]};
    end else if (nib_nz[2]) begin
      lzc_out = {3'd1, nib_cnt[2]};
    end else if (nib_nz[1]) begin
      lzc_out = {3'd2, nib_cnt[1]};
    end else if (nib_nz[0]) begin
      lzc_out = {3'd3, nib_cnt[0]};
    end else begin
      lzc_out = 5'd16;
    end
  end

endmodule

// ==== design/stage_2.sv ====
/* Encoder stage 2
   New range for one CDF symbol or up to three chained booleans,
   with one-round renormalization producing the shift count d */
`timescale 1ns/1ps

module stage_2 (
  input  logic                          comp_mux,
  input  logic                          bool_flag_1,
  input  logic                          bool_flag_2,
  input  logic                          bool_flag_3,
  input  logic [ec_pkg::EC_RANGE_W-1:0] UU,
  input  logic [ec_pkg::EC_RANGE_W-1:0] VV,
  input  logic [ec_pkg::EC_RANGE_W-1:0] in_range,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_u,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_v,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_uv,
  input  logic [3:0]                    in_symbol_1,
  input  logic [3:0]                    in_symbol_2,
  input  logic [3:0]                    in_symbol_3,
  output logic [ec_pkg::EC_RANGE_W-1:0] out_range,
  output logic [ec_pkg::EC_D_W-1:0]     out_d_1,
  output logic [ec_pkg::EC_D_W-1:0]     out_d_2,
  output logic [ec_pkg::EC_D_W-1:0]     out_d_3
);

  logic [ec_pkg::EC_RANGE_W-1:0] range_cdf;
  logic [ec_pkg::EC_RANGE_W-1:0] range_bool_1;
  logic [ec_pkg::EC_RANGE_W-1:0] range_bool_2;
  logic [ec_pkg::EC_RANGE_W-1:0] range_bool_3;
  logic [ec_pkg::EC_RANGE_W-1:0] range_bool;
  logic [ec_pkg::EC_D_W-1:0]     d_cdf;
  logic [ec_pkg::EC_D_W-1:0]     d_bool_1;

  s2_cdf u_cdf (
    .comp_mux  (comp_mux),
    .UU        (UU),
    .VV        (VV),
    .in_range  (in_range),
    .lut_u     (lut_u),
    .lut_v     (lut_v),
    .lut_uv    (lut_uv),
    .d_out     (d_cdf),
    .out_range (range_cdf)
  );

  // Booleans chained, each one renormalized before the next
  s2_bool u_bool_1 (
    .in_range  (in_range),
    .symbol    (in_symbol_1),
    .out_d     (d_bool_1),
    .out_range (range_bool_1)
  );

  s2_bool u_bool_2 (
    .in_range  (range_bool_1),
    .symbol    (in_symbol_2),
    .out_d     (out_d_2),
    .out_range (range_bool_2)
  );

  s2_bool u_bool_3 (
    .in_range  (range_bool_2),
    .symbol    (in_symbol_3),
    .out_d     (out_d_3),
    .out_range (range_bool_3)
  );

  // Last active boolean gives the range
  assign range_bool = bool_flag_3 ? range_bool_3 :
                      bool_flag_2 ? range_bool_2 :
                      range_bool_1;

  assign out_range = bool_flag_1 ? range_bool : range_cdf;
  assign out_d_1   = bool_flag_1 ? d_bool_1 : d_cdf;

endmodule

module s2_cdf (
  input  logic                          comp_mux,
  input  logic [ec_pkg::EC_RANGE_W-1:0] UU,
  input  logic [ec_pkg::EC_RANGE_W-1:0] VV,
  input  logic [ec_pkg::EC_RANGE_W-1:0] in_range,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_u,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_v,
  input  logic [ec_pkg::EC_RANGE_W-1:0] lut_uv,
  output logic [ec_pkg::EC_D_W-1:0]     d_out,
  output logic [ec_pkg::EC_RANGE_W-1:0] out_range
);

  logic [7:0]                    rr;
  logic [23:0]                   prod_u;
  logic [23:0]                   prod_v;
  logic [ec_pkg::EC_RANGE_W-1:0] u_scaled;
  logic [ec_pkg::EC_RANGE_W-1:0] v_scaled;
  logic [ec_pkg::EC_RANGE_W-1:0] u_full;
  logic [ec_pkg::EC_RANGE_W-1:0] v_full;
  logic [ec_pkg::EC_RANGE_W-1:0] range_raw;

  // Top byte of the range scales both bounds
  assign rr     = in_range[15:8];
  assign prod_u = rr * UU;
  assign prod_v = rr * VV;

  // Halved products, below 2^16 for Q15 bounds
  assign u_scaled = prod_u[16:1];
  assign v_scaled = prod_v[16:1];
  assign u_full   = u_scaled + lut_u;
  assign v_full   = v_scaled + lut_v;

  // u - v below the top of the CDF, otherwise the rest of the range
  assign range_raw = comp_mux ? (u_full - v_full) : (in_range - v_full);

  s2_renormalization u_norm (
    .range_raw   (range_raw),
    .d_out       (d_out),
    .range_final (out_range)
  );

endmodule

module s2_bool (
  input  logic [ec_pkg::EC_RANGE_W-1:0] in_range,
  input  logic [3:0]                    symbol,
  output logic [ec_pkg::EC_D_W-1:0]     out_d,
  output logic [ec_pkg::EC_RANGE_W-1:0] out_range
);

  logic [ec_pkg::EC_RANGE_W-1:0] v;
  logic [ec_pkg::EC_RANGE_W-1:0] range_raw;

  // Fixed 50% probability, (R >> 8) * 128 plus the floor
  assign v = {1'b0, in_range[15:8], 7'd0} + ec_pkg::EC_MIN_PROB;
  assign range_raw = symbol[0] ? v : (in_range - v);

  // Worst case leaves two leading zeros, no LZC needed
  assign out_d = range_raw[15] ? 5'd0 :
                 range_raw[14] ? 5'd1 :
                 5'd2;
  assign out_range = range_raw << out_d;

endmodule

module s2_renormalization (
  input  logic [ec_pkg::EC_RANGE_W-1:0] range_raw,
  output logic [ec_pkg::EC_D_W-1:0]     d_out,
  output logic [ec_pkg::EC_RANGE_W-1:0] range_final
);

  logic lzc_nonzero;

  leading_zero u_lzc (
    .in_range (range_raw),
    .v        (lzc_nonzero),
    .lzc_out  (d_out)
  );

  // Zero raw range shifts out to zero
  assign range_final = lzc_nonzero ? (range_raw << d_out) : '0;

endmodule

// ==== design/ec_stage_1.sv ====
/* Encoder stage 1
   Registers the scaled CDF bounds, probability-floor terms and boolean fields */
`timescale 1ns/1ps

module ec_stage_1 (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  logic                          in_is_bool,
  input  ec_pkg::ec_req_t               in_req,
  output logic                          s1_valid,
  output logic                          comp_mux,
  output logic                          bool_flag_1,
  output logic                          bool_flag_2,
  output logic                          bool_flag_3,
  output logic [ec_pkg::EC_RANGE_W-1:0] UU,
  output logic [ec_pkg::EC_RANGE_W-1:0] VV,
  output logic [ec_pkg::EC_RANGE_W-1:0] lut_u,
  output logic [ec_pkg::EC_RANGE_W-1:0] lut_v,
  output logic [ec_pkg::EC_RANGE_W-1:0] lut_uv,
  output logic [3:0]                    symbol_1,
  output logic [3:0]                    symbol_2,
  output logic [3:0]                    symbol_3
);

  logic [ec_pkg::EC_RANGE_W-1:0] cnt_v;
  logic [ec_pkg::EC_RANGE_W-1:0] cnt_u;
  logic [ec_pkg::EC_RANGE_W-1:0] lut_u_next;
  logic [ec_pkg::EC_RANGE_W-1:0] lut_v_next;

  // Symbols above s, and above s-1
  assign cnt_v = {12'd0, in_req.cdf.nsyms} - {12'd0, in_req.cdf.sym};
  assign cnt_u = cnt_v + 16'd1;
  assign lut_u_next = cnt_u * ec_pkg::EC_MIN_PROB;
  assign lut_v_next = cnt_v * ec_pkg::EC_MIN_PROB;

  // Valid flag is the only control bit here
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Payload captured on accept only
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (in_is_bool) begin
        // CDF terms cleared, stage 2 takes the bool path
        comp_mux    <= 1'b0;
        UU          <= '0;
        VV          <= '0;
        lut_u       <= '0;
        lut_v       <= '0;
        lut_uv      <= '0;
        bool_flag_1 <= (in_req.boolean.count >= 2'd1);
        bool_flag_2 <= (in_req.boolean.count >= 2'd2);
        bool_flag_3 <= (in_req.boolean.count == 2'd3);
        symbol_1    <= {3'b000, in_req.boolean.bits[0]};
        symbol_2    <= {3'b000, in_req.boolean.bits[1]};
        symbol_3    <= {3'b000, in_req.boolean.bits[2]};
      end else begin
        // u path exists only below the top of the CDF
        comp_mux    <= (in_req.cdf.fl < 16'h8000);
        UU          <= in_req.cdf.fl >> 6;
        VV          <= in_req.cdf.fh >> 6;
        lut_u       <= lut_u_next;
        lut_v       <= lut_v_next;
        lut_uv      <= lut_u_next - lut_v_next;
        bool_flag_1 <= 1'b0;
        bool_flag_2 <= 1'b0;
        bool_flag_3 <= 1'b0;
        symbol_1    <= '0;
        symbol_2    <= '0;
        symbol_3    <= '0;
      end
    end
  end

endmodule

// ==== design/ec_ctrl_fsm.sv ====
/* Encoder controller
   Sequences idle, range init, encoding and pipeline drain */
`timescale 1ns/1ps

module ec_ctrl_fsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic flush,
  input  logic s1_valid,
  input  logic res_valid,
  output logic req_ready,
  output logic init_range,
  output logic done
);

  ec_pkg::ec_state_t state;
  ec_pkg::ec_state_t state_next;
  logic              drained;

  // Nothing left in stage 1 or the result register
  assign drained = ~s1_valid & ~res_valid;

  always_comb begin
    state_next = state;
    case (state)
      ec_pkg::IDLE: begin
        if (start) begin
          state_next = ec_pkg::INIT;
        end
      end
      // Single cycle, range reload and counter clear
      ec_pkg::INIT: begin
        state_next = ec_pkg::ENCODE;
      end
      ec_pkg::ENCODE: begin
        if (flush) begin
          state_next = ec_pkg::DRAIN;
        end
      end
      ec_pkg::DRAIN: begin
        if (drained) begin
          state_next = ec_pkg::IDLE;
        end
      end
      default: begin
        state_next = ec_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ec_pkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      // One pulse as DRAIN exits
      done  <= (state == ec_pkg::DRAIN) && drained;
    end
  end

  // Requests taken only while encoding
  assign req_ready  = (state == ec_pkg::ENCODE);
  assign init_range = (state == ec_pkg::INIT);

endmodule

// ==== design/ec_shift_counter.sv ====
/* Shift counter
   Totals the renormalization shifts and the number of coded requests */
`timescale 1ns/1ps

module ec_shift_counter #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        clear,
  input  logic                        add_valid,
  input  logic [ec_pkg::EC_D_W+1:0]   add_shift,
  output logic [COUNT_WIDTH-1:0]      total_shift,
  output logic [COUNT_WIDTH-1:0]      req_count
);

  logic [COUNT_WIDTH-1:0] shift_ext;

  // Sized to the counter, any width wraps cleanly
  assign shift_ext = COUNT_WIDTH'(add_shift);

  always_ff @(posedge clk) begin
    if (reset) begin
      total_shift <= '0;
      req_count   <= '0;
    end else if (clear) begin
      total_shift <= '0;
      req_count   <= '0;
    end else if (add_valid) begin
      // Output bits owed so far
      total_shift <= total_shift + shift_ext;
      req_count   <= req_count + 1'b1;
    end
  end

endmodule

// ==== design/ec_range_top.sv ====
/* Range encoder top
   Stage 1, stage 2 and the range register loop, with result and shift totals */
`timescale 1ns/1ps

module ec_range_top #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          flush,
  input  logic                          req_valid,
  input  logic                          req_is_bool,
  input  ec_pkg::ec_req_t               req_word,
  output logic                          req_ready,
  output logic                          res_valid,
  output logic                          done,
  output logic [ec_pkg::EC_RANGE_W-1:0] res_range,
  output logic [ec_pkg::EC_D_W+1:0]     res_shift,
  output logic [COUNT_WIDTH-1:0]        total_shift,
  output logic [COUNT_WIDTH-1:0]        req_count
);

  localparam int SHIFT_W = ec_pkg::EC_D_W + 2;

  logic                          accept;
  logic                          init_range;
  logic                          s1_valid;
  logic                          comp_mux;
  logic                          bool_flag_1;
  logic                          bool_flag_2;
  logic                          bool_flag_3;
  logic [ec_pkg::EC_RANGE_W-1:0] UU;
  logic [ec_pkg::EC_RANGE_W-1:0] VV;
  logic [ec_pkg::EC_RANGE_W-1:0] lut_u;
  logic [ec_pkg::EC_RANGE_W-1:0] lut_v;
  logic [ec_pkg::EC_RANGE_W-1:0] lut_uv;
  logic [3:0]                    symbol_1;
  logic [3:0]                    symbol_2;
  logic [3:0]                    symbol_3;
  logic [ec_pkg::EC_RANGE_W-1:0] range_q;
  logic [ec_pkg::EC_RANGE_W-1:0] range_next;
  logic [ec_pkg::EC_D_W-1:0]     d_1;
  logic [ec_pkg::EC_D_W-1:0]     d_2;
  logic [ec_pkg::EC_D_W-1:0]     d_3;
  logic [SHIFT_W-1:0]            shift_sum;

  assign accept = req_valid & req_ready;

  ec_ctrl_fsm u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .flush      (flush),
    .s1_valid   (s1_valid),
    .res_valid  (res_valid),
    .req_ready  (req_ready),
    .init_range (init_range),
    .done       (done)
  );

  ec_stage_1 u_stage_1 (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (accept),
    .in_is_bool  (req_is_bool),
    .in_req      (req_word),
    .s1_valid    (s1_valid),
    .comp_mux    (comp_mux),
    .bool_flag_1 (bool_flag_1),
    .bool_flag_2 (bool_flag_2),
    .bool_flag_3 (bool_flag_3),
    .UU          (UU),
    .VV          (VV),
    .lut_u       (lut_u),
    .lut_v       (lut_v),
    .lut_uv      (lut_uv),
    .symbol_1    (symbol_1),
    .symbol_2    (symbol_2),
    .symbol_3    (symbol_3)
  );

  // Combinational on stage 1 and the current range
  stage_2 u_stage_2 (
    .comp_mux    (comp_mux),
    .bool_flag_1 (bool_flag_1),
    .bool_flag_2 (bool_flag_2),
    .bool_flag_3 (bool_flag_3),
    .UU          (UU),
    .VV          (VV),
    .in_range    (range_q),
    .lut_u       (lut_u),
    .lut_v       (lut_v),
    .lut_uv      (lut_uv),
    .in_symbol_1 (symbol_1),
    .in_symbol_2 (symbol_2),
    .in_symbol_3 (symbol_3),
    .out_range   (range_next),
    .out_d_1     (d_1),
    .out_d_2     (d_2),
    .out_d_3     (d_3)
  );

  // Shift of the active paths only
  assign shift_sum = SHIFT_W'(d_1) +
                     (bool_flag_2 ? SHIFT_W'(d_2) : '0) +
                     (bool_flag_3 ? SHIFT_W'(d_3) : '0);

  // Range loop, closes in one cycle for back-to-back requests
  always_ff @(posedge clk) begin
    if (reset || init_range) begin
      range_q <= ec_pkg::EC_RANGE_INIT;
    end else if (s1_valid) begin
      range_q <= range_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  // Result payload, consumer never stalls
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res_range <= range_next;
      res_shift <= shift_sum;
    end
  end

  ec_shift_counter #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_shift_counter (
    .clk         (clk),
    .reset       (reset),
    .clear       (init_range),
    .add_valid   (res_valid),
    .add_shift   (res_shift),
    .total_shift (total_shift),
    .req_count   (req_count)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
/* Testbench clock source
   Free-running clock with a set period, starts low */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period per toggle
  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// ==== sim/ec_range_asserts.sv ====
/* Range encoder checks
   Bound into the top, covering the request handshake and range normalization */
`timescale 1ns/1ps

module ec_range_asserts (
  input logic                          clk,
  input logic                          reset,
  input logic                          req_ready,
  input logic                          res_valid,
  input logic [ec_pkg::EC_RANGE_W-1:0] res_range,
  input ec_pkg::ec_state_t             state
);

  // Failures seen so far, read back by the testbench
  int assert_fails = 0;

  // Results only while encoding or draining
  a_res_in_state: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> (state == ec_pkg::ENCODE || state == ec_pkg::DRAIN))
    else begin
      assert_fails++;
      $error("res_valid high outside ENCODE and DRAIN");
    end

  // Renormalized range keeps its top bit
  a_range_norm: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> res_range[15])
    else begin
      assert_fails++;
      $error("res_range not normalized, bit 15 clear");
    end

  // No requests taken coming out of reset
  a_ready_reset: assert property (@(posedge clk) reset |=> !req_ready)
    else begin
      assert_fails++;
      $error("req_ready high after a reset cycle");
    end

endmodule

bind ec_range_top ec_range_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .req_ready (req_ready),
  .res_valid (res_valid),
  .res_range (res_range),
  .state     (u_ctrl.state)
);

// ==== sim/ec_range_tb.sv ====
/* Range encoder testbench
   Directed and random requests checked against a model of stages 1 and 2 */
`timescale 1ns/1ps

module ec_range_tb;

  localparam int COUNT_W = 16;
  localparam int N_DIRECT_CDF = 6;
  localparam int N_BOOL = 14;
  localparam int N_RANDOM = 200;
  localparam int N_REQ = 1 + N_DIRECT_CDF + N_BOOL + N_RANDOM + 2;
  localparam int TIMEOUT_CYCLES = 20 * N_REQ + 200;

  logic                          clk;
  logic                          reset;
  logic                          start;
  logic                          flush;
  logic                          req_valid;
  logic                          req_is_bool;
  ec_pkg::ec_req_t               req_word;
  logic                          req_ready;
  logic                          res_valid;
  logic                          done;
  logic [ec_pkg::EC_RANGE_W-1:0] res_range;
  logic [ec_pkg::EC_D_W+1:0]     res_shift;
  logic [COUNT_W-1:0]            total_shift;
  logic [COUNT_W-1:0]            req_count;

  int seed = 32'h2bcb_468e;
  int cycle = 0;
  int value_errors = 0;
  int protocol_errors = 0;
  int assert_errors = 0;

  // Model range and running totals
  logic [ec_pkg::EC_RANGE_W-1:0] model_range;
  int                            model_total;
  int                            model_count;

  // Expected results in issue order
  logic [ec_pkg::EC_RANGE_W-1:0] exp_range_q[$];
  logic [ec_pkg::EC_D_W+1:0]     exp_shift_q[$];
  int                            exp_edge_q[$];

  tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

  ec_range_top #(
    .COUNT_WIDTH (COUNT_W)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .flush       (flush),
    .req_valid   (req_valid),
    .req_is_bool (req_is_bool),
    .req_word    (req_word),
    .req_ready   (req_ready),
    .res_valid   (res_valid),
    .done        (done),
    .res_range   (res_range),
    .res_shift   (res_shift),
    .total_shift (total_shift),
    .req_count   (req_count)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_range(input string name, input logic [ec_pkg::EC_RANGE_W-1:0] got,
                             input logic [ec_pkg::EC_RANGE_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic check_shift(input string name, input logic [ec_pkg::EC_D_W+1:0] got,
                             input logic [ec_pkg::EC_D_W+1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                             input logic [COUNT_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  // Value in [0, n) from the seeded stream
  function automatic int draw(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic int count_leading_zeros(input logic [15:0] x);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    for (int i = 15; i >= 0; i--) begin
      seen = seen | x[i];
      if (!seen) begin
        n++;
      end
    end
    return n;
  endfunction

  // CDF symbol, scaled bounds plus probability floor, then full renormalization
  task automatic model_cdf(input int fl, input int fh, input int sym, input int nsyms,
                           output logic [15:0] new_range, output int shift);
    int          rr;
    int          u;
    int          v;
    logic [15:0] raw;
    rr = int'(model_range >> 8);
    u = ((rr * (fl >> 6)) >> 1) + 4 * (nsyms - sym + 1);
    v = ((rr * (fh >> 6)) >> 1) + 4 * (nsyms - sym);
    if (fl < 32768) begin
      raw = 16'(u - v);
    end else begin
      raw = 16'(int'(model_range) - v);
    end
    shift = count_leading_zeros(raw);
    new_range = raw << shift;
  endtask

  // Booleans at one half each, range carried from one to the next
  task automatic model_bool(input int count, input int bits,
                            output logic [15:0] new_range, output int shift);
    logic [15:0] rng;
    logic [15:0] v;
    logic [15:0] raw;
    int          d;
    rng = model_range;
    shift = 0;
    for (int i = 0; i < count; i++) begin
      v = 16'(int'(rng >> 8) * 128 + 4);
      raw = bits[i] ? v : rng - v;
      d = raw[15] ? 0 : (raw[14] ? 1 : 2);
      rng = raw << d;
      shift += d;
    end
    new_range = rng;
  endtask

  task automatic offer_request(input logic is_bool, input ec_pkg::ec_req_t word);
    req_valid = 1'b1;
    req_is_bool = is_bool;
    req_word = word;
    while (!req_ready) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_request();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic push_expected(input logic [15:0] range, input int shift);
    exp_range_q.push_back(range);
    exp_shift_q.push_back(7'(shift));
    // Accept at the next edge, result taken two edges later
    exp_edge_q.push_back(cycle + 3);
    model_range = range;
    model_total += shift;
    model_count++;
  endtask

  task automatic send_cdf(input int fl, input int fh, input int sym, input int nsyms);
    ec_pkg::ec_req_t word;
    logic [15:0]     r;
    int              d;
    word = '0;
    word.cdf.fl = 16'(fl);
    word.cdf.fh = 16'(fh);
    word.cdf.sym = 4'(sym);
    word.cdf.nsyms = 4'(nsyms);
    offer_request(1'b0, word);
    model_cdf(fl, fh, sym, nsyms, r, d);
    push_expected(r, d);
    finish_request();
  endtask

  task automatic send_bool(input int count, input int bits);
    ec_pkg::ec_req_t word;
    logic [15:0]     r;
    int              d;
    word = '0;
    word.boolean.count = 2'(count);
    word.boolean.bits = 3'(bits);
    offer_request(1'b1, word);
    model_bool(count, bits, r, d);
    push_expected(r, d);
    finish_request();
  endtask

  task automatic wait_results();
    while (exp_range_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic start_encoder();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!req_ready) begin
      @(negedge clk);
    end
    model_range = ec_pkg::EC_RANGE_INIT;
    model_total = 0;
    model_count = 0;
  endtask

  task automatic flush_and_check();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    while (!done) begin
      @(negedge clk);
    end
    if (exp_range_q.size() != 0) begin
      protocol_errors++;
      $display("done raised with %0d results still missing", exp_range_q.size());
    end
    check_count("total_shift", total_shift, COUNT_W'(model_total));
    check_count("req_count", req_count, COUNT_W'(model_count));
    check_flag("req_ready", req_ready, 1'b0);
  endtask

  // Results compared in order, with their arrival edge
  always @(negedge clk) begin : result_monitor
    int want_edge;
    if (!reset && res_valid) begin
      if (exp_range_q.size() == 0) begin
        protocol_errors++;
        $display("Result arrived with no request outstanding at cycle %0d", cycle);
      end else begin
        check_range("res_range", res_range, exp_range_q.pop_front());
        check_shift("res_shift", res_shift, exp_shift_q.pop_front());
        want_edge = exp_edge_q.pop_front();
        if (cycle + 1 != want_edge) begin
          protocol_errors++;
          $display("Result taken at edge %0d instead of edge %0d", cycle + 1, want_edge);
        end
      end
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic test_reset_and_init();
    check_flag("req_ready", req_ready, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("res_valid", res_valid, 1'b0);
    start_encoder();
    check_count("total_shift", total_shift, '0);
    // Single bool 0 from the initial range
    send_bool(1, 0);
    wait_results();
  endtask

  task automatic test_cdf_symbols();
    // Top of the CDF, R - v path
    send_cdf(32768, 16384, 0, 2);
    send_cdf(32768, 30000, 0, 4);
    // Below the top, u - v path
    send_cdf(16384, 0, 1, 2);
    send_cdf(20000, 8000, 2, 8);
    // Small probabilities, long shifts
    send_cdf(1000, 0, 14, 15);
    send_cdf(32768, 32576, 0, 3);
    wait_results();
  endtask

  task automatic test_bool_triples();
    for (int count = 1; count <= 3; count++) begin
      for (int bits = 0; bits < (1 << count); bits++) begin
        send_bool(count, bits);
      end
    end
    wait_results();
  endtask

  task automatic test_back_to_back();
    int nsyms;
    int sym;
    int fl;
    int fh;
    for (int i = 0; i < N_RANDOM; i++) begin
      if (draw(3) == 0) begin
        send_bool(1 + draw(3), draw(8));
      end else begin
        // Bounds at least 64 per symbol apart
        nsyms = 2 + draw(14);
        sym = draw(nsyms);
        fl = (draw(4) == 0) ? 32768 : 64 * nsyms + draw(32768 - 64 * nsyms);
        fh = draw(fl - 64 * nsyms + 1);
        send_cdf(fl, fh, sym, nsyms);
      end
    end
    wait_results();
  endtask

  task automatic test_restart();
    start_encoder();
    check_count("total_shift", total_shift, '0);
    check_count("req_count", req_count, '0);
    send_bool(2, 1);
    send_cdf(16384, 0, 1, 2);
    wait_results();
    flush_and_check();
  endtask

  initial begin : watchdog
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    start = 1'b0;
    flush = 1'b0;
    req_valid = 1'b0;
    req_is_bool = 1'b0;
    req_word = '0;
    model_range = ec_pkg::EC_RANGE_INIT;
    model_total = 0;
    model_count = 0;
    apply_reset();
    test_reset_and_init();
    test_cdf_symbols();
    test_bool_triples();
    test_back_to_back();
    flush_and_check();
    test_restart();
    repeat (2) @(negedge clk);
    assert_errors = dut.u_asserts.assert_fails;
    $display("Errors: value %0d, protocol %0d, assertion %0d",
             value_errors, protocol_errors, assert_errors);
    if (value_errors + protocol_errors + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== ec_range_top.f ====
design/ec_pkg.sv
design/leading_zero.sv
design/stage_2.sv
design/ec_stage_1.sv
design/ec_ctrl_fsm.sv
design/ec_shift_counter.sv
design/ec_range_top.sv
sim/tb_clock_gen.sv
sim/ec_range_asserts.sv
sim/ec_range_tb.sv

// ==== Makefile ====
# Verilator build and run for the range encoder testbench

VERILATOR ?= verilator
TOP       ?= ec_range_tb
FILELIST  ?= ec_range_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
